/* common/lsu_pkg.sv */
/*
 * shared types for the load/store path: opcode enum, size codes,
 * request, bus, load-response and writeback structs
 */
`default_nettype none

package lsu_pkg;

	// data and address width
	localparam int XLEN    = 64;
	localparam int STRB_W  = XLEN / 8;

	// widest tag any struct carries, top level uses the low bits
	localparam int TAG_MAX = 8;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	// access size codes
	localparam logic [1:0] SIZE_B = 2'd0;
	localparam logic [1:0] SIZE_H = 2'd1;
	localparam logic [1:0] SIZE_W = 2'd2;
	localparam logic [1:0] SIZE_D = 2'd3;

	typedef enum logic [3:0] {
		OP_LB,
		OP_LH,
		OP_LW,
		OP_LD,
		OP_LBU,
		OP_LHU,
		OP_LWU,
		OP_SB,
		OP_SH,
		OP_SW,
		OP_SD,
		OP_FENCE,
		OP_FENCE_I
	} lsu_op_e;

	// decoded instruction from execute
	typedef struct packed {
		lsu_op_e              op;
		logic [TAG_MAX-1:0]   rd;
		logic [XLEN-1:0]      addr;
		logic [XLEN-1:0]      wdata;
	} lsu_req_t;

	// stage 1 to stage 2, data and strobe already on their byte lanes
	typedef struct packed {
		logic                 is_load;
		logic                 is_store;
		logic                 is_fence;
		logic [TAG_MAX-1:0]   rd;
		logic [XLEN-1:0]      addr;
		logic [XLEN-1:0]      wdata;
		logic [STRB_W-1:0]    wstrb;
		logic [1:0]           size;
		logic                 unsigned_ld;
	} lsu_bus_t;

	// stage 2 to stage 3
	typedef struct packed {
		logic                 valid;
		logic [TAG_MAX-1:0]   rd;
		logic [2:0]           offset;
		logic [1:0]           size;
		logic                 unsigned_ld;
		logic [XLEN-1:0]      rdata;
	} lsu_ld_t;

	typedef struct packed {
		logic                 valid;
		logic [TAG_MAX-1:0]   rd;
		logic [XLEN-1:0]      data;
	} lsu_wb_t;

endpackage

`default_nettype wire

/* lsu/lsu_issue.sv */
/*
 * stage 1: accepts an instruction, decodes the opcode and builds
 * lane-shifted store data and byte strobes for the bus stage
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_issue import lsu_pkg::*; (
	input  wire                CLK,
	input  wire                reset,
	input  wire                exe_valid,
	input  wire lsu_req_t      exe_param,
	input  wire                flush,
	input  wire                busy,
	output logic               exe_ready,
	output lsu_bus_t           bus_req,
	output logic               bus_req_valid
);

	logic              accept;
	logic              is_load;
	logic              is_store;
	logic              is_fence;
	logic              unsigned_ld;
	logic [1:0]        size;
	logic [STRB_W-1:0] base_strb;
	logic [2:0]        align_mask;

	assign accept = exe_valid && exe_ready;

	always_comb begin
		is_load     = exe_param.op inside {OP_LB, OP_LH, OP_LW, OP_LD,
			OP_LBU, OP_LHU, OP_LWU};
		is_store    = exe_param.op inside {OP_SB, OP_SH, OP_SW, OP_SD};
		is_fence    = !is_load && !is_store;
		unsigned_ld = exe_param.op inside {OP_LBU, OP_LHU, OP_LWU};
		case (exe_param.op)
			OP_LB, OP_LBU, OP_SB: size = SIZE_B;
			OP_LH, OP_LHU, OP_SH: size = SIZE_H;
			OP_LW, OP_LWU, OP_SW: size = SIZE_W;
			default:              size = SIZE_D;
		endcase
	end

	// strobe for the access size, before lane shift
	always_comb begin
		case (size)
			SIZE_B:  base_strb = 8'h01;
			SIZE_H:  base_strb = 8'h03;
			SIZE_W:  base_strb = 8'h0f;
			default: base_strb = 8'hff;
		endcase
	end

	assign align_mask = 3'((4'd1 << size) - 4'd1);

	// payload, only meaningful with bus_req_valid
	always_ff @(posedge CLK) begin
		if (accept) begin
			bus_req.is_load     <= is_load;
			bus_req.is_store    <= is_store;
			bus_req.is_fence    <= is_fence;
			bus_req.rd          <= exe_param.rd;
			bus_req.addr        <= exe_param.addr;
			bus_req.wdata       <= exe_param.wdata << {exe_param.addr[2:0], 3'b000};
			bus_req.wstrb       <= is_store ? (base_strb << exe_param.addr[2:0]) : '0;
			bus_req.size        <= size;
			bus_req.unsigned_ld <= unsigned_ld;
		end
	end

	// a flush on the accept edge drops the instruction before the bus
	always_ff @(posedge CLK) begin
		if (reset) begin
			bus_req_valid <= 1'b0;
			exe_ready     <= 1'b0;
		end else begin
			bus_req_valid <= accept && !flush;
			exe_ready     <= !busy && !bus_req_valid && !accept;
		end
	end

	a_aligned: assert property (@(posedge CLK) disable iff (reset)
		(accept && !is_fence) |-> ((exe_param.addr[2:0] & align_mask) == 3'b000))
		else $error("misaligned access at %h", exe_param.addr);

endmodule

`default_nettype wire

/* lsu/lsu_axi_master.sv */
/*
 * stage 2: AXI4-Lite master, one transaction at a time, plus the
 * flush cancel flag and the load response towards stage 3
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_axi_master import lsu_pkg::*; (
	input  wire                CLK,
	input  wire                reset,
	input  wire lsu_bus_t      bus_req,
	input  wire                bus_req_valid,
	input  wire                flush,

	output logic [XLEN-1:0]    awaddr,
	output logic               awvalid,
	input  wire                awready,

	output logic [XLEN-1:0]    wdata,
	output logic [STRB_W-1:0]  wstrb,
	output logic               wvalid,
	input  wire                wready,

	input  wire                bvalid,
	input  wire [1:0]          bresp,
	output logic               bready,

	output logic [XLEN-1:0]    araddr,
	output logic               arvalid,
	input  wire                arready,

	input  wire                rvalid,
	input  wire [XLEN-1:0]     rdata,
	input  wire [1:0]          rresp,
	output logic               rready,

	output logic               busy,
	output lsu_ld_t            ld_rsp
);

	typedef enum logic [2:0] {
		IDLE,
		WR_REQ,
		WR_RESP,
		RD_REQ,
		RD_RESP
	} state_e;

	state_e   state;
	lsu_bus_t req_q;
	logic     cancel;
	logic     aw_done;
	logic     w_done;

	// held for the whole transaction
	always_ff @(posedge CLK) begin
		if (bus_req_valid && state == IDLE)
			req_q <= bus_req;
	end

	assign awaddr = req_q.addr;
	assign araddr = req_q.addr;
	assign wdata  = req_q.wdata;
	assign wstrb  = req_q.wstrb;

	// responses are taken as soon as they show up
	assign bready = 1'b1;
	assign rready = 1'b1;

	assign busy = (state != IDLE);

	// each write channel may finish on its own edge
	assign aw_done = !awvalid || awready;
	assign w_done  = !wvalid || wready;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state        <= IDLE;
			awvalid      <= 1'b0;
			wvalid       <= 1'b0;
			arvalid      <= 1'b0;
			cancel       <= 1'b0;
			ld_rsp.valid <= 1'b0;
		end else begin
			ld_rsp.valid <= 1'b0;
			if (state != IDLE && flush)
				cancel <= 1'b1;

			case (state)
				IDLE: begin
					if (bus_req_valid) begin
						cancel             <= flush;
						ld_rsp.rd          <= bus_req.rd;
						ld_rsp.offset      <= bus_req.addr[2:0];
						ld_rsp.size        <= bus_req.size;
						ld_rsp.unsigned_ld <= bus_req.unsigned_ld;
						if (bus_req.is_fence) begin
							// fences retire here, no bus traffic
							ld_rsp.valid <= !flush;
							ld_rsp.rdata <= '0;
						end else if (bus_req.is_store) begin
							awvalid <= 1'b1;
							wvalid  <= 1'b1;
							state   <= WR_REQ;
						end else begin
							arvalid <= 1'b1;
							state   <= RD_REQ;
						end
					end
				end

				WR_REQ: begin
					if (awvalid && awready)
						awvalid <= 1'b0;
					if (wvalid && wready)
						wvalid <= 1'b0;
					if (aw_done && w_done)
						state <= WR_RESP;
				end

				WR_RESP: begin
					if (bvalid && bready) begin
						// stores retire with zero data
						ld_rsp.valid <= !cancel && !flush;
						ld_rsp.rdata <= '0;
						cancel       <= 1'b0;
						state        <= IDLE;
					end
				end

				RD_REQ: begin
					if (arvalid && arready) begin
						arvalid <= 1'b0;
						state   <= RD_RESP;
					end
				end

				RD_RESP: begin
					if (rvalid && rready) begin
						ld_rsp.valid <= !cancel && !flush;
						ld_rsp.rdata <= rdata;
						cancel       <= 1'b0;
						state        <= IDLE;
					end
				end

				default: state <= IDLE;
			endcase
		end
	end

	a_aw_hold: assert property (@(posedge CLK) disable iff (reset)
		(awvalid && !awready) |=> awvalid)
		else $error("awvalid dropped before handshake");

	a_w_hold: assert property (@(posedge CLK) disable iff (reset)
		(wvalid && !wready) |=> wvalid)
		else $error("wvalid dropped before handshake");

	a_ar_hold: assert property (@(posedge CLK) disable iff (reset)
		(arvalid && !arready) |=> arvalid)
		else $error("arvalid dropped before handshake");

	// no overlap between a read and a write anywhere on the bus
	a_no_mix: assert property (@(posedge CLK) disable iff (reset)
		!((arvalid || rvalid) && (awvalid || wvalid || bvalid)))
		else $error("read and write pending together");

	a_resp_okay: assert property (@(posedge CLK) disable iff (reset)
		(!bvalid || bresp == RESP_OKAY) && (!rvalid || rresp == RESP_OKAY))
		else $error("non-OKAY response from scratchpad");

endmodule

`default_nettype wire

/* lsu/lsu_load_align.sv */
/*
 * stage 3: moves load data down from its byte lane, extends it
 * and registers the writeback pulse
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
	input  wire                CLK,
	input  wire                reset,
	input  wire lsu_ld_t       ld_rsp,
	input  wire                flush,
	output lsu_wb_t            wb
);

	logic [XLEN-1:0] shifted;
	logic [XLEN-1:0] ext_data;

	assign shifted = ld_rsp.rdata >> {ld_rsp.offset, 3'b000};

	// stores and fences arrive with zero rdata and stay zero here
	always_comb begin
		case (ld_rsp.size)
			SIZE_B: begin
				if (ld_rsp.unsigned_ld)
					ext_data = {56'b0, shifted[7:0]};
				else
					ext_data = {{56{shifted[7]}}, shifted[7:0]};
			end
			SIZE_H: begin
				if (ld_rsp.unsigned_ld)
					ext_data = {48'b0, shifted[15:0]};
				else
					ext_data = {{48{shifted[15]}}, shifted[15:0]};
			end
			SIZE_W: begin
				if (ld_rsp.unsigned_ld)
					ext_data = {32'b0, shifted[31:0]};
				else
					ext_data = {{32{shifted[31]}}, shifted[31:0]};
			end
			default: ext_data = shifted;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			wb.valid <= 1'b0;
		end else begin
			// late flush still kills the result
			wb.valid <= ld_rsp.valid && !flush;
			if (ld_rsp.valid) begin
				wb.rd   <= ld_rsp.rd;
				wb.data <= ext_data;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/axil_scratchpad.sv */
/*
 * AXI4-Lite slave over a 64-bit word memory with byte strobes,
 * one-cycle ready pulses and registered responses
 */
`timescale 1ns/1ps
`default_nettype none

module axil_scratchpad import lsu_pkg::*; #(
	parameter int MEM_WORDS = 512
) (
	input  wire                CLK,
	input  wire                reset,

	input  wire [XLEN-1:0]     awaddr,
	input  wire                awvalid,
	output logic               awready,

	input  wire [XLEN-1:0]     wdata,
	input  wire [STRB_W-1:0]   wstrb,
	input  wire                wvalid,
	output logic               wready,

	output logic               bvalid,
	output logic [1:0]         bresp,
	input  wire                bready,

	input  wire [XLEN-1:0]     araddr,
	input  wire                arvalid,
	output logic               arready,

	output logic               rvalid,
	output logic [XLEN-1:0]    rdata,
	output logic [1:0]         rresp,
	input  wire                rready
);

	localparam int IDX_W = $clog2(MEM_WORDS);

	logic [XLEN-1:0]  mem [MEM_WORDS];
	logic [IDX_W-1:0] widx;
	logic [IDX_W-1:0] ridx;

	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = '0;
	end

	// word index wraps at the memory depth
	assign widx = IDX_W'(awaddr[XLEN-1:3] % MEM_WORDS);
	assign ridx = IDX_W'(araddr[XLEN-1:3] % MEM_WORDS);

	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

	always_ff @(posedge CLK) begin
		if (reset) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			// address and data accepted together, single-cycle pulse
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready  <= awvalid && wvalid && !awready && !bvalid;
			if (awvalid && awready)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			arready <= arvalid && !arready && !rvalid;
			if (arvalid && arready)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (awvalid && awready && wvalid && wready) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (wstrb[b])
					mem[widx][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

	// whole word back, the master picks the lanes
	always_ff @(posedge CLK) begin
		if (arvalid && arready)
			rdata <= mem[ridx];
	end

endmodule

`default_nettype wire

/* verilog/lsu_top.sv */
/*
 * load/store path top: issue, AXI master and load align stages
 * wired to the scratchpad
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; #(
	parameter int RD_W      = 6,
	parameter int MEM_WORDS = 512
) (
	input  wire                CLK,
	input  wire                reset,
	input  wire                exe_valid,
	output logic               exe_ready,
	input  wire lsu_req_t      exe_param,
	input  wire                flush,
	output lsu_wb_t            wb
);

	// tag bits above RD_W are tied low
	localparam logic [TAG_MAX-1:0] RD_MASK = {TAG_MAX{1'b1}} >> (TAG_MAX - RD_W);

	lsu_req_t          issue_param;
	lsu_bus_t          bus_req;
	lsu_ld_t           ld_rsp;
	logic              bus_req_valid;
	logic              busy;

	logic [XLEN-1:0]   awaddr;
	logic              awvalid;
	logic              awready;
	logic [XLEN-1:0]   wdata;
	logic [STRB_W-1:0] wstrb;
	logic              wvalid;
	logic              wready;
	logic              bvalid;
	logic [1:0]        bresp;
	logic              bready;
	logic [XLEN-1:0]   araddr;
	logic              arvalid;
	logic              arready;
	logic              rvalid;
	logic [XLEN-1:0]   rdata;
	logic [1:0]        rresp;
	logic              rready;

	assign issue_param = {exe_param.op, exe_param.rd & RD_MASK, exe_param.addr, exe_param.wdata};

	lsu_issue u_issue (
		.CLK(CLK), .reset(reset), .exe_valid(exe_valid), .exe_param(issue_param),
		.flush(flush), .busy(busy), .exe_ready(exe_ready), .bus_req(bus_req),
		.bus_req_valid(bus_req_valid)
	);

	lsu_axi_master u_axi_master (
		.CLK(CLK), .reset(reset), .bus_req(bus_req), .bus_req_valid(bus_req_valid),
		.flush(flush), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready), .araddr(araddr),
		.arvalid(arvalid), .arready(arready), .rvalid(rvalid), .rdata(rdata),
		.rresp(rresp), .rready(rready), .busy(busy), .ld_rsp(ld_rsp)
	);

	lsu_load_align u_load_align (
		.CLK(CLK), .reset(reset), .ld_rsp(ld_rsp), .flush(flush), .wb(wb)
	);

	axil_scratchpad #(.MEM_WORDS(MEM_WORDS)) u_scratchpad (
		.CLK(CLK), .reset(reset), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready), .araddr(araddr),
		.arvalid(arvalid), .arready(arready), .rvalid(rvalid), .rdata(rdata),
		.rresp(rresp), .rready(rready)
	);

endmodule

`default_nettype wire

/* verification/tb_lsu_top.sv */
/*
 * testbench for lsu_top: table of loads, stores and fences checked
 * against a byte-wide shadow memory, plus latency, handshake and flush checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top import lsu_pkg::*; ();

	localparam int RD_W         = 6;
	localparam int MEM_WORDS    = 64;
	localparam int MEM_BYTES    = MEM_WORDS * 8;
	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY  = 2;
	localparam int MAX_GAP      = 3;
	localparam logic [31:0] SEED = 32'hd4a6d544;

	typedef struct packed {
		lsu_op_e     op;
		logic [15:0] addr;
		logic [7:0]  tag;
		logic        flush;
		logic        rnd;
		logic [63:0] data;
	} step_t;

	localparam int NUM_STEPS   = 44;
	localparam int WATCHDOG_NS = NUM_STEPS * 20 * CLK_PERIOD;

	// op, address, tag, flush after accept, random data, data
	localparam step_t STEPS [NUM_STEPS] = '{
		'{OP_LD,      16'h0040, 8'h01, 1'b0, 1'b0, 64'h0},
		'{OP_SD,      16'h0000, 8'h02, 1'b0, 1'b0, 64'h0123_4567_89ab_cdef},
		'{OP_LD,      16'h0000, 8'h03, 1'b0, 1'b0, 64'h0},
		'{OP_SB,      16'h0003, 8'h04, 1'b0, 1'b0, 64'h5a},
		'{OP_SH,      16'h0006, 8'h05, 1'b0, 1'b1, 64'h0},
		'{OP_LD,      16'h0000, 8'h06, 1'b0, 1'b0, 64'h0},
		'{OP_FENCE,   16'h0000, 8'h07, 1'b0, 1'b0, 64'h0},
		'{OP_SD,      16'h0008, 8'h08, 1'b0, 1'b1, 64'h0},
		'{OP_SW,      16'h000c, 8'h09, 1'b0, 1'b0, 64'hffff_ffff_89ab_cdef},
		'{OP_SB,      16'h0009, 8'h0a, 1'b0, 1'b1, 64'h0},
		'{OP_LD,      16'h0008, 8'h0b, 1'b0, 1'b0, 64'h0},
		'{OP_SD,      16'h0010, 8'h8c, 1'b0, 1'b0, 64'h7fff_8000_7f80_ff81},
		'{OP_SD,      16'h0018, 8'h0d, 1'b0, 1'b0, 64'h8000_0001_0000_7fff},
		'{OP_LB,      16'h0010, 8'h0e, 1'b0, 1'b0, 64'h0},
		'{OP_LBU,     16'h0010, 8'h0f, 1'b0, 1'b0, 64'h0},
		'{OP_LB,      16'h0013, 8'h10, 1'b0, 1'b0, 64'h0},
		'{OP_LBU,     16'h0012, 8'h91, 1'b0, 1'b0, 64'h0},
		'{OP_LH,      16'h0010, 8'h12, 1'b0, 1'b0, 64'h0},
		'{OP_LHU,     16'h0010, 8'h13, 1'b0, 1'b0, 64'h0},
		'{OP_LH,      16'h0012, 8'h14, 1'b0, 1'b0, 64'h0},
		'{OP_LH,      16'h0014, 8'h15, 1'b0, 1'b0, 64'h0},
		'{OP_LHU,     16'h0016, 8'h16, 1'b0, 1'b0, 64'h0},
		'{OP_LW,      16'h0010, 8'h17, 1'b0, 1'b0, 64'h0},
		'{OP_LWU,     16'h0014, 8'h18, 1'b0, 1'b0, 64'h0},
		'{OP_LW,      16'h001c, 8'h19, 1'b0, 1'b0, 64'h0},
		'{OP_LWU,     16'h001c, 8'h1a, 1'b0, 1'b0, 64'h0},
		'{OP_LD,      16'h0018, 8'h1b, 1'b0, 1'b0, 64'h0},
		'{OP_FENCE_I, 16'h0000, 8'h3c, 1'b0, 1'b0, 64'h0},
		'{OP_SW,      16'h0020, 8'h1d, 1'b1, 1'b1, 64'h0},
		'{OP_LD,      16'h0020, 8'h1e, 1'b0, 1'b0, 64'h0},
		'{OP_LB,      16'h0010, 8'h1f, 1'b1, 1'b0, 64'h0},
		'{OP_FENCE,   16'h0000, 8'h20, 1'b1, 1'b0, 64'h0},
		'{OP_SB,      16'h0027, 8'h21, 1'b1, 1'b0, 64'h80},
		'{OP_LBU,     16'h0027, 8'h22, 1'b0, 1'b0, 64'h0},
		'{OP_LB,      16'h0027, 8'h23, 1'b0, 1'b0, 64'h0},
		'{OP_SD,      16'h0210, 8'h24, 1'b0, 1'b1, 64'h0},
		'{OP_LD,      16'h0010, 8'h25, 1'b0, 1'b0, 64'h0},
		'{OP_SH,      16'h0032, 8'h26, 1'b0, 1'b1, 64'h0},
		'{OP_LH,      16'h0032, 8'h27, 1'b0, 1'b0, 64'h0},
		'{OP_LHU,     16'h0032, 8'h28, 1'b0, 1'b0, 64'h0},
		'{OP_SD,      16'h01f8, 8'h29, 1'b0, 1'b1, 64'h0},
		'{OP_LWU,     16'h01fc, 8'h2a, 1'b0, 1'b0, 64'h0},
		'{OP_FENCE_I, 16'h0000, 8'h2b, 1'b1, 1'b0, 64'h0},
		'{OP_LD,      16'h01f8, 8'hff, 1'b0, 1'b0, 64'h0}
	};

	logic       CLK;
	logic       reset;
	logic       exe_valid;
	logic       exe_ready;
	lsu_req_t   exe_param;
	logic       flush;
	lsu_wb_t    wb;

	logic [7:0] shadow [MEM_BYTES];
	int         wb_pulses = 0;
	int         exp_pulses = 0;

	lsu_top #(.RD_W(RD_W), .MEM_WORDS(MEM_WORDS)) DUT (
		.CLK(CLK), .reset(reset), .exe_valid(exe_valid), .exe_ready(exe_ready),
		.exe_param(exe_param), .flush(flush), .wb(wb)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// every writeback pulse the DUT produces
	always @(negedge CLK) begin
		if (!reset && wb.valid)
			wb_pulses++;
	end

	function automatic int op_bytes(lsu_op_e op);
		case (op)
			OP_LB, OP_LBU, OP_SB: return 1;
			OP_LH, OP_LHU, OP_SH: return 2;
			OP_LW, OP_LWU, OP_SW: return 4;
			default:              return 8;
		endcase
	endfunction

	function automatic logic is_store(lsu_op_e op);
		return op inside {OP_SB, OP_SH, OP_SW, OP_SD};
	endfunction

	function automatic logic is_fence(lsu_op_e op);
		return op inside {OP_FENCE, OP_FENCE_I};
	endfunction

	function automatic logic is_unsigned(lsu_op_e op);
		return op inside {OP_LBU, OP_LHU, OP_LWU};
	endfunction

	// byte address wraps at the scratchpad size
	function automatic int byte_index(logic [63:0] addr, int i);
		return int'((addr + 64'(i)) % 64'(MEM_BYTES));
	endfunction

	function automatic void write_shadow(lsu_op_e op, logic [63:0] addr, logic [63:0] data);
		for (int i = 0; i < op_bytes(op); i++)
			shadow[byte_index(addr, i)] = data[8*i +: 8];
	endfunction

	// little-endian gather, then sign fill for signed loads
	function automatic logic [63:0] expected_load(lsu_op_e op, logic [63:0] addr);
		logic [63:0] val;
		int          nbytes;
		val = '0;
		nbytes = op_bytes(op);
		for (int i = 0; i < nbytes; i++)
			val[8*i +: 8] = shadow[byte_index(addr, i)];
		if (!is_unsigned(op) && nbytes < 8 && val[8*nbytes-1]) begin
			for (int i = nbytes; i < 8; i++)
				val[8*i +: 8] = 8'hff;
		end
		return val;
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(negedge CLK);
			check_value("wb.valid while idle", 64'(wb.valid), 64'd0);
			@(posedge CLK);
			#(DRIVE_DELAY);
		end
	endtask

	task automatic run_step(input step_t s);
		logic [63:0] data;
		logic [63:0] expected;
		int          lat;
		int          flush_at;
		int          n;
		idle_cycles(int'($urandom % (MAX_GAP + 1)));
		data = s.rnd ? {$urandom, $urandom} : s.data;
		lat = is_fence(s.op) ? 3 : 6;
		// flush lands somewhere between stage 1 and the writeback register
		flush_at = s.flush ? 1 + int'($urandom % 32'(lat - 1)) : 0;
		if (is_store(s.op)) begin
			write_shadow(s.op, 64'(s.addr), data);
			expected = '0;
		end else if (is_fence(s.op)) begin
			expected = '0;
		end else begin
			expected = expected_load(s.op, 64'(s.addr));
		end

		exe_param.op    = s.op;
		exe_param.rd    = s.tag;
		exe_param.addr  = 64'(s.addr);
		exe_param.wdata = data;
		exe_valid = 1'b1;
		@(negedge CLK);
		while (!exe_ready)
			@(negedge CLK);
		@(posedge CLK);
		#(DRIVE_DELAY);
		exe_valid = 1'b0;
		if (!s.flush)
			exp_pulses++;

		// n counts clock edges after the accepting one
		for (n = 1; n <= lat + 1; n++) begin
			flush = (n == flush_at);
			@(negedge CLK);
			check_value("exe_ready while in flight", 64'(exe_ready), 64'(n >= lat));
			if (n == lat && !s.flush) begin
				check_value("wb.valid at latency", 64'(wb.valid), 64'd1);
				check_value("wb.rd", 64'(wb.rd[RD_W-1:0]), 64'(s.tag[RD_W-1:0]));
				check_value("wb.data", wb.data, expected);
			end else begin
				check_value("wb.valid outside its slot", 64'(wb.valid), 64'd0);
			end
			@(posedge CLK);
			#(DRIVE_DELAY);
		end
		flush = 1'b0;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout after %0d ns, the DUT stopped accepting or answering", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		CLK       = 1'b0;
		reset     = 1'b1;
		exe_valid = 1'b0;
		exe_param = '0;
		flush     = 1'b0;
		void'($urandom(SEED));
		for (int i = 0; i < MEM_BYTES; i++)
			shadow[i] = 8'h00;

		repeat (RESET_CYCLES - 1) @(posedge CLK);
		@(negedge CLK);
		check_value("exe_ready in reset", 64'(exe_ready), 64'd0);
		check_value("wb.valid in reset", 64'(wb.valid), 64'd0);
		@(posedge CLK);
		#(DRIVE_DELAY);
		reset = 1'b0;

		for (int s = 0; s < NUM_STEPS; s++)
			run_step(STEPS[s]);
		idle_cycles(4);

		if (wb_pulses == exp_pulses) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			check_value("writeback pulse count", 64'(wb_pulses), 64'(exp_pulses));
		end
	end

endmodule

`default_nettype wire

/* sim.f */
common/lsu_pkg.sv
lsu/lsu_issue.sv
lsu/lsu_axi_master.sv
lsu/lsu_load_align.sv
verilog/axil_scratchpad.sv
verilog/lsu_top.sv
verification/tb_lsu_top.sv

/* Makefile */
# Verilator build and run of the load/store path testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
